// File: timed_flag.f
verilog/timed_flag_pkg.sv
verilog/tf_cfg_if.sv
verilog/tf_buf_if.sv
verilog/tf_apb_regs.sv
verilog/tf_burst_fetch.sv
verilog/tf_pingpong_buf.sv
verilog/tf_flag_scanner.sv
verilog/timed_flag_top.sv
bench/tb_timed_flag_asserts.sv
bench/tb_timed_flag.sv

// File: Makefile
TOP = tb_timed_flag
OBJ = obj_dir
LOG = sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal -j 0 \
		--top-module $(TOP) -Mdir $(OBJ) -f timed_flag.f

# pass only if the log holds the pass line
run: compile
	./$(OBJ)/V$(TOP) | tee $(LOG)
	grep -qF "*** TEST PASSED ***" $(LOG)

clean:
	rm -rf $(OBJ) $(LOG)

// File: bench/tb_timed_flag.sv
`timescale 1ns/10ps
`default_nettype none

module tb_timed_flag;

   localparam int MEM_WORDS  = 256;
   localparam int BANK_WORDS = 64;
   localparam int N_RUNS     = 7;

   typedef struct packed {
      logic [7:0]  ext_addr;   // word index into the memory model
      logic [7:0]  length;
      logic [31:0] maximum;
      logic [31:0] delay;
      logic        dis;
      logic [15:0] samples;
      logic [7:0]  flags;      // expected flag count
   } run_row_t;

   // flags of a row come from the table fetched by the row before
   localparam run_row_t RUNS [N_RUNS] = '{
      '{8'd0, 8'd4, 32'd1000, 32'd0,  1'b0, 16'd40, 8'd0},
      '{8'd2, 8'd5, 32'd1000, 32'd0,  1'b0, 16'd40, 8'd8},
      '{8'd8, 8'd3, 32'd1000, 32'd25, 1'b0, 16'd50, 8'd6},   // delay hides 4
      '{8'd1, 8'd4, 32'd60,   32'd0,  1'b0, 16'd70, 8'd4},   // cut at 59
      '{8'd0, 8'd2, 32'd1000, 32'd0,  1'b1, 16'd40, 8'd0},
      '{8'd5, 8'd6, 32'd1000, 32'd3,  1'b0, 16'd16, 8'd3},
      '{8'd0, 8'd1, 32'd1000, 32'd0,  1'b0, 16'd70, 8'd12}
   };

   logic                   clk           = 1'b0;
   logic                   rst           = 1'b1;
   logic                   psel_i        = 1'b0;
   logic                   penable_i     = 1'b0;
   logic                   pwrite_i      = 1'b0;
   timed_flag_pkg::apb_addr_t paddr_i    = '0;
   timed_flag_pkg::word_t  pwdata_i      = '0;
   timed_flag_pkg::word_t  prdata_o;
   logic                   pready_o;
   logic                   pslverr_o;
   logic                   mem_valid_o;
   logic                   mem_ready_i   = 1'b0;
   timed_flag_pkg::word_t  mem_addr_o;
   timed_flag_pkg::len_t   mem_len_o;
   timed_flag_pkg::word_t  mem_rdata_i   = '0;
   logic                   mem_last_i    = 1'b0;
   timed_flag_pkg::count_t count_i       = '0;
   logic                   count_valid_i = 1'b0;
   logic                   flag_o;
   logic                   done_o;

   timed_flag_pkg::word_t  mem_words [MEM_WORDS];
   integer                 seed     = 32'hc20b_65aa;
   logic [31:0]            rnd;
   bit                     accepted = 1'b0;
   int                     beat     = 0;
   logic [31:0]            exp_addr = '0;
   int                     exp_len  = 1;

   // reference model state
   timed_flag_pkg::flag_t  cur_tbl [$];
   timed_flag_pkg::flag_t  next_tbl [$];
   int                     tbl_pos;
   longint                 delay_left;
   longint                 cur_max;
   bit                     cur_dis;
   bit                     live;

   timed_flag_top dut0 (
      .clk           (clk),
      .rst           (rst),
      .psel_i        (psel_i),
      .penable_i     (penable_i),
      .pwrite_i      (pwrite_i),
      .paddr_i       (paddr_i),
      .pwdata_i      (pwdata_i),
      .prdata_o      (prdata_o),
      .pready_o      (pready_o),
      .pslverr_o     (pslverr_o),
      .mem_valid_o   (mem_valid_o),
      .mem_ready_i   (mem_ready_i),
      .mem_addr_o    (mem_addr_o),
      .mem_len_o     (mem_len_o),
      .mem_rdata_i   (mem_rdata_i),
      .mem_last_i    (mem_last_i),
      .count_i       (count_i),
      .count_valid_i (count_valid_i),
      .flag_o        (flag_o),
      .done_o        (done_o)
   );

   initial begin
      forever #10 clk = ~clk;
   end

   task automatic abort(input string why);
      $display("%s", why);
      $display("*** TEST FAILED ***");
      $fatal(1, "simulation stopped on error");
   endtask

   task automatic check(input string name, input logic [31:0] expected,
                        input logic [31:0] actual);
      if (actual !== expected) begin
         abort($sformatf("FAIL %s: expected %h, actual %h", name, expected, actual));
      end
   endtask

   // memory model samples the bus mid cycle
   always @(negedge clk) begin
      accepted = mem_valid_o && mem_ready_i;
      if (!mem_valid_o) begin
         beat = 0;
      end else begin
         check("burst address", exp_addr, mem_addr_o);
         check("burst length", 32'(exp_len - 1), 32'(mem_len_o));
         if (beat >= exp_len) abort("mem_valid_o stayed high after the last beat");
      end
   end

   always @(posedge clk) begin
      if (accepted) beat = beat + 1;
      rnd = $random(seed);
      mem_ready_i <= (rnd[1:0] != 2'b00);   // ready 3 cycles in 4
      mem_rdata_i <= mem_words[(exp_addr + 32'(beat)) % MEM_WORDS];
      mem_last_i  <= (beat == exp_len - 1);
   end

   always @(negedge clk) begin
      if (dut0.asrt0.fail_cnt != 0) abort("a bound assertion failed");
   end

   task automatic apb_write(input logic [7:0] addr, input logic [31:0] data,
                            input logic exp_err);
      @(posedge clk);
      psel_i    <= 1'b1;
      penable_i <= 1'b0;
      pwrite_i  <= 1'b1;
      paddr_i   <= addr;
      pwdata_i  <= data;
      @(posedge clk);
      penable_i <= 1'b1;
      @(negedge clk);
      check($sformatf("pslverr on write to %h", addr), 32'(exp_err), 32'(pslverr_o));
      @(posedge clk);
      psel_i    <= 1'b0;
      penable_i <= 1'b0;
   endtask

   task automatic apb_read(input logic [7:0] addr, output logic [31:0] data,
                           input logic exp_err);
      @(posedge clk);
      psel_i    <= 1'b1;
      penable_i <= 1'b0;
      pwrite_i  <= 1'b0;
      paddr_i   <= addr;
      @(posedge clk);
      penable_i <= 1'b1;
      @(negedge clk);
      data = prdata_o;
      check($sformatf("pslverr on read of %h", addr), 32'(exp_err), 32'(pslverr_o));
      @(posedge clk);
      psel_i    <= 1'b0;
      penable_i <= 1'b0;
   endtask

   task automatic readback(input logic [7:0] addr, input logic [31:0] data);
      logic [31:0] rd;
      apb_write(addr, data, 1'b0);
      apb_read(addr, rd, 1'b0);
      check($sformatf("readback of offset %h", addr), data, rd);
   endtask

   task automatic check_registers();
      logic [31:0] rd;
      apb_read(timed_flag_pkg::REG_STATUS, rd, 1'b0);
      check("status after reset", 32'h1, rd);
      readback(timed_flag_pkg::REG_EXT_ADDR, 32'h1234_5678);
      readback(timed_flag_pkg::REG_LENGTH, 32'h0000_00c3);
      readback(timed_flag_pkg::REG_MAXIMUM, 32'hdead_0001);
      readback(timed_flag_pkg::REG_DELAY, 32'h0000_0f0f);
      readback(timed_flag_pkg::REG_CTRL, 32'h0000_0002);   // disable without start
      readback(timed_flag_pkg::REG_CTRL, 32'h0000_0000);
      apb_read(8'h18, rd, 1'b1);
      apb_write(8'h18, 32'hffff_ffff, 1'b1);
   endtask

   // one count sample through the flag rules
   function automatic bit predict_flag(input logic [31:0] cnt);
      bit hit;
      bit flagged;
      hit     = (tbl_pos < cur_tbl.size()) && (cnt[15:0] == cur_tbl[tbl_pos]);
      flagged = hit && (delay_left == 0) && !cur_dis && live;
      if (hit) tbl_pos++;
      if (delay_left != 0) delay_left--;
      if (longint'(cnt) + 1 >= cur_max) live = 1'b0;
      return flagged;
   endfunction

   task automatic start_row(input int r);
      timed_flag_pkg::word_t w;
      cur_tbl = next_tbl;
      next_tbl.delete();
      for (int i = 0; i < int'(RUNS[r].length) && i < BANK_WORDS; i++) begin
         w = mem_words[(int'(RUNS[r].ext_addr) + i) % MEM_WORDS];
         next_tbl.push_back(w[15:0]);   // low half first
         next_tbl.push_back(w[31:16]);
      end
      tbl_pos    = 0;
      delay_left = longint'(RUNS[r].delay);
      cur_max    = longint'(RUNS[r].maximum);
      cur_dis    = RUNS[r].dis;
      live       = 1'b1;
      exp_addr   = 32'(RUNS[r].ext_addr);
      exp_len    = int'(RUNS[r].length);
      apb_write(timed_flag_pkg::REG_EXT_ADDR, exp_addr, 1'b0);
      apb_write(timed_flag_pkg::REG_LENGTH, 32'(RUNS[r].length), 1'b0);
      apb_write(timed_flag_pkg::REG_MAXIMUM, RUNS[r].maximum, 1'b0);
      apb_write(timed_flag_pkg::REG_DELAY, RUNS[r].delay, 1'b0);
      apb_write(timed_flag_pkg::REG_CTRL, {30'b0, RUNS[r].dis, 1'b1}, 1'b0);
   endtask

   // flag_o shows up one cycle after its sample
   task automatic run_samples(input int r, input int n, output int nflags);
      bit want;
      bit prev;
      prev   = 1'b0;
      nflags = 0;
      for (int i = 0; i <= n; i++) begin
         @(posedge clk);
         want = 1'b0;
         if (i < n) begin
            count_i       <= 32'(i);
            count_valid_i <= 1'b1;
            want = predict_flag(32'(i));
         end else begin
            count_valid_i <= 1'b0;
         end
         @(negedge clk);
         check($sformatf("row %0d sample %0d flag", r, i - 1), 32'(prev), 32'(flag_o));
         if (flag_o) nflags++;
         prev = want;
      end
   endtask

   task automatic wait_done();
      @(negedge clk);
      while (!done_o) @(negedge clk);
   endtask

   function automatic int watchdog_cycles();
      int total;
      total = 300;   // reset and register checks
      for (int i = 0; i < N_RUNS; i++) begin
         total += 4 * int'(RUNS[i].length) + int'(RUNS[i].samples) + 80;
      end
      return total;
   endfunction

   initial begin
      logic [31:0] rd;
      logic [31:0] exp_status;
      int          nflags;
      for (int a = 0; a < MEM_WORDS; a++) begin
         mem_words[a] = {16'(6 * a + 5), 16'(6 * a + 2)};
      end
      repeat (10) @(posedge clk);
      rst <= 1'b0;
      check_registers();
      for (int r = 0; r < N_RUNS; r++) begin
         @(negedge clk);
         start_row(r);
         repeat (4) @(posedge clk);   // scanner prefetch
         @(negedge clk);
         // a live table keeps the scanner busy
         if (cur_tbl.size() != 0 && !cur_dis) begin
            check($sformatf("row %0d done during scan", r), 32'h0, 32'(done_o));
         end
         run_samples(r, int'(RUNS[r].samples), nflags);
         check($sformatf("row %0d flag count", r), 32'(RUNS[r].flags), 32'(nflags));
         wait_done();
         apb_read(timed_flag_pkg::REG_STATUS, rd, 1'b0);
         exp_status = 32'h1 | ((r % 2 == 0) ? 32'h2 : 32'h0);   // bank flips per run
         check($sformatf("row %0d status", r), exp_status, rd);
      end
      if (dut0.asrt0.fail_cnt == 0) begin
         $display("*** TEST PASSED ***");
         $finish;
      end else begin
         abort("bound assertions reported failures");
      end
   end

   initial begin
      #(watchdog_cycles() * 20);
      abort("watchdog expired before all runs finished");
   end

endmodule

`default_nettype wire

// File: bench/tb_timed_flag_asserts.sv
`timescale 1ns/10ps
`default_nettype none

module tb_timed_flag_asserts (
   input wire logic                   clk,
   input wire logic                   rst,
   input wire logic                   mem_valid_o,
   input wire logic                   mem_ready_i,
   input wire timed_flag_pkg::word_t  mem_addr_o,
   input wire timed_flag_pkg::len_t   mem_len_o,
   input wire logic                   pready_o,
   input wire logic                   flag_o,
   input wire logic                   count_valid_i,
   input wire timed_flag_pkg::count_t count_i
);

   int fail_cnt = 0;

   // request held while the bus stalls
   a_req_hold: assert property (@(posedge clk) disable iff (rst)
      mem_valid_o && !mem_ready_i |=> mem_valid_o && $stable(mem_addr_o) && $stable(mem_len_o))
      else begin
         $error("read request changed while waiting on ready");
         fail_cnt++;
      end

   a_pready: assert property (@(posedge clk) disable iff (rst) pready_o)
      else begin
         $error("pready_o went low");
         fail_cnt++;
      end

   // each flag needs a sample of its own
   a_flag_sample: assert property (@(posedge clk) disable iff (rst)
      flag_o |-> $past(count_valid_i) &&
                 (!$past(flag_o) || ($past(count_i) != $past(count_i, 2))))
      else begin
         $error("flag_o without a new matching sample");
         fail_cnt++;
      end

endmodule

bind timed_flag_top tb_timed_flag_asserts asrt0 (
   .clk           (clk),
   .rst           (rst),
   .mem_valid_o   (mem_valid_o),
   .mem_ready_i   (mem_ready_i),
   .mem_addr_o    (mem_addr_o),
   .mem_len_o     (mem_len_o),
   .pready_o      (pready_o),
   .flag_o        (flag_o),
   .count_valid_i (count_valid_i),
   .count_i       (count_i)
);

`default_nettype wire

// File: verilog/timed_flag_top.sv
`timescale 1ns/10ps
`default_nettype none

module timed_flag_top #(
   parameter int BUF_AW = 6
) (
   input  wire logic                      clk,
   input  wire logic                      rst,
   // apb slave
   input  wire logic                      psel_i,
   input  wire logic                      penable_i,
   input  wire logic                      pwrite_i,
   input  wire timed_flag_pkg::apb_addr_t paddr_i,
   input  wire timed_flag_pkg::word_t     pwdata_i,
   output timed_flag_pkg::word_t          prdata_o,
   output logic                           pready_o,
   output logic                           pslverr_o,
   // read bus
   output logic                           mem_valid_o,
   input  wire logic                      mem_ready_i,
   output timed_flag_pkg::word_t          mem_addr_o,
   output timed_flag_pkg::len_t           mem_len_o,
   input  wire timed_flag_pkg::word_t     mem_rdata_i,
   input  wire logic                      mem_last_i,
   // event count in, flags out
   input  wire timed_flag_pkg::count_t    count_i,
   input  wire logic                      count_valid_i,
   output logic                           flag_o,
   output logic                           done_o
);

   logic busy;
   logic scan_done;

   tf_cfg_if #(.BUF_AW(BUF_AW)) cfg_if0 ();
   tf_buf_if #(.BUF_AW(BUF_AW)) buf_if0 ();

   tf_apb_regs regs0 (
      .clk       (clk),
      .rst       (rst),
      .psel_i    (psel_i),
      .penable_i (penable_i),
      .pwrite_i  (pwrite_i),
      .paddr_i   (paddr_i),
      .pwdata_i  (pwdata_i),
      .prdata_o  (prdata_o),
      .pready_o  (pready_o),
      .pslverr_o (pslverr_o),
      .done_i    (done_o),
      .bank_i    (buf_if0.fill_bank),
      .busy_i    (busy),
      .cfg       (cfg_if0)
   );

   tf_burst_fetch #(.BUF_AW(BUF_AW)) fetch0 (
      .clk         (clk),
      .rst         (rst),
      .cfg         (cfg_if0),
      .buf_w       (buf_if0),
      .mem_valid_o (mem_valid_o),
      .mem_ready_i (mem_ready_i),
      .mem_addr_o  (mem_addr_o),
      .mem_len_o   (mem_len_o),
      .mem_rdata_i (mem_rdata_i),
      .mem_last_i  (mem_last_i),
      .busy_o      (busy)
   );

   tf_pingpong_buf #(.BUF_AW(BUF_AW)) buf0 (
      .clk   (clk),
      .rst   (rst),
      .buf_p (buf_if0),
      .run_i (cfg_if0.run)
   );

   tf_flag_scanner #(.BUF_AW(BUF_AW)) scan0 (
      .clk           (clk),
      .rst           (rst),
      .cfg           (cfg_if0),
      .buf_r         (buf_if0),
      .count_i       (count_i),
      .count_valid_i (count_valid_i),
      .flag_o        (flag_o),
      .scan_done_o   (scan_done)
   );

   assign done_o = scan_done & ~mem_valid_o;   // burst finished too

endmodule

`default_nettype wire

// File: verilog/tf_flag_scanner.sv
`timescale 1ns/10ps
`default_nettype none

module tf_flag_scanner #(
   parameter int BUF_AW = 6
) (
   input  wire logic                   clk,
   input  wire logic                   rst,
   tf_cfg_if.scan                      cfg,
   tf_buf_if.reader                    buf_r,
   input  wire timed_flag_pkg::count_t count_i,
   input  wire logic                   count_valid_i,
   output logic                        flag_o,
   output logic                        scan_done_o
);

   typedef enum logic [1:0] {
      S_IDLE,
      S_LOAD,
      S_WAIT,
      S_SCAN
   } state_t;

   state_t                 state;
   logic [BUF_AW-1:0]      ptr;         // next word to fetch
   logic [BUF_AW+1:0]      idx;         // values consumed
   logic [BUF_AW+1:0]      total;
   logic                   half;        // on upper half of cur_word
   logic                   live;        // maximum not passed yet
   timed_flag_pkg::count_t delay_cnt;
   timed_flag_pkg::word_t  cur_word;
   timed_flag_pkg::flag_t  cur_val;
   logic                   active;
   logic                   hit;
   logic                   past_max;
   logic                   exhausted;

   assign cur_val   = half ? cur_word[31:16] : cur_word[15:0];
   assign exhausted = (state == S_SCAN) && (idx == total);
   assign active    = (state == S_SCAN) && (idx != total);
   assign hit       = count_valid_i && active && (count_i[15:0] == cur_val);
   assign past_max  = ({1'b0, count_i} + 33'd1) >= {1'b0, cfg.maximum};

   assign buf_r.rd_addr = ptr;
   assign buf_r.rd_en   = (state == S_LOAD) || (state == S_WAIT) || (hit && half);

   assign scan_done_o = (state == S_IDLE) || exhausted || cfg.disabled || !live;

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         state     <= S_IDLE;
         ptr       <= '0;
         idx       <= '0;
         total     <= '0;
         half      <= 1'b0;
         live      <= 1'b0;
         delay_cnt <= '0;
         flag_o    <= 1'b0;
      end else begin
         flag_o <= hit && (delay_cnt == '0) && !cfg.disabled && live;
         if (cfg.run) begin
            state     <= S_LOAD;
            ptr       <= '0;
            idx       <= '0;
            half      <= 1'b0;
            live      <= 1'b1;
            delay_cnt <= cfg.delay;
         end else begin
            if (count_valid_i && state != S_IDLE) begin
               if (delay_cnt != '0) delay_cnt <= delay_cnt - 1'b1;
               if (past_max) live <= 1'b0;
            end
            case (state)
               S_LOAD: begin
                  state <= S_WAIT;
                  ptr   <= ptr + 1'b1;
                  total <= {buf_r.rd_beats, 1'b0};   // two values per word
               end
               S_WAIT: begin
                  state <= S_SCAN;
                  ptr   <= ptr + 1'b1;
               end
               S_SCAN: begin
                  if (hit) begin
                     idx  <= idx + 1'b1;
                     half <= ~half;
                     if (half) ptr <= ptr + 1'b1;
                  end
               end
               default: ;
            endcase
         end
      end
   end

   // rd_data always holds the word after cur_word
   always_ff @(posedge clk) begin
      if (state == S_WAIT || (hit && half)) cur_word <= buf_r.rd_data;
   end

endmodule

`default_nettype wire

// File: verilog/tf_pingpong_buf.sv
`timescale 1ns/10ps
`default_nettype none

module tf_pingpong_buf #(
   parameter int BUF_AW = 6
) (
   input  wire logic clk,
   input  wire logic rst,
   tf_buf_if.buffer  buf_p,
   input  wire logic run_i
);

   localparam int WORDS = 2 ** (BUF_AW + 1);   // both banks

   timed_flag_pkg::word_t mem [WORDS];
   logic [BUF_AW:0]       beats [2];
   logic                  fill;

   assign buf_p.fill_bank = fill;
   assign buf_p.rd_beats  = beats[!fill];

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         fill     <= 1'b0;
         beats[0] <= '0;
         beats[1] <= '0;
      end else begin
         if (run_i) fill <= ~fill;
         // writes are in order so the last one leaves the count
         if (buf_p.wr_en) beats[fill] <= {1'b0, buf_p.wr_addr} + 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (buf_p.wr_en) begin
         mem[{fill, buf_p.wr_addr}] <= buf_p.wr_data;
      end
      if (buf_p.rd_en) begin
         buf_p.rd_data <= mem[{~fill, buf_p.rd_addr}];
      end
   end

endmodule

`default_nettype wire

// File: verilog/tf_burst_fetch.sv
`timescale 1ns/10ps
`default_nettype none

module tf_burst_fetch #(
   parameter int BUF_AW = 6
) (
   input  wire logic                  clk,
   input  wire logic                  rst,
   tf_cfg_if.fetch                    cfg,
   tf_buf_if.writer                   buf_w,
   output logic                       mem_valid_o,
   input  wire logic                  mem_ready_i,
   output timed_flag_pkg::word_t      mem_addr_o,
   output timed_flag_pkg::len_t       mem_len_o,
   input  wire timed_flag_pkg::word_t mem_rdata_i,
   input  wire logic                  mem_last_i,
   output logic                       busy_o
);

   typedef enum logic [1:0] {
      S_IDLE,
      S_BURST,
      S_FLUSH
   } state_t;

   state_t          state;
   logic [BUF_AW:0] beat_cnt;   // stops at beat_lim
   logic [BUF_AW:0] beat_lim;
   logic            accept;

   assign mem_valid_o = (state == S_BURST);
   assign busy_o      = (state != S_IDLE);
   assign accept      = mem_valid_o & mem_ready_i;

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         state       <= S_IDLE;
         beat_cnt    <= '0;
         beat_lim    <= '0;
         buf_w.wr_en <= 1'b0;
      end else begin
         buf_w.wr_en <= 1'b0;
         case (state)
            S_IDLE: begin
               if (cfg.run) begin
                  state    <= S_BURST;
                  beat_cnt <= '0;
                  beat_lim <= cfg.fill_beats;
               end
            end
            S_BURST: begin
               if (accept) begin
                  if (beat_cnt != beat_lim) begin   // clip at bank size
                     buf_w.wr_en <= 1'b1;
                     beat_cnt    <= beat_cnt + 1'b1;
                  end
                  if (mem_last_i) state <= S_FLUSH;
               end
            end
            S_FLUSH: state <= S_IDLE;   // last write lands this cycle
            default: state <= S_IDLE;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (state == S_IDLE && cfg.run) begin
         mem_addr_o <= cfg.ext_addr;
         mem_len_o  <= cfg.length - 1'b1;
      end
      if (accept) begin
         buf_w.wr_addr <= beat_cnt[BUF_AW-1:0];
         buf_w.wr_data <= mem_rdata_i;
      end
   end

endmodule

`default_nettype wire

// File: verilog/tf_apb_regs.sv
`timescale 1ns/10ps
`default_nettype none

module tf_apb_regs (
   input  wire logic                      clk,
   input  wire logic                      rst,
   input  wire logic                      psel_i,
   input  wire logic                      penable_i,
   input  wire logic                      pwrite_i,
   input  wire timed_flag_pkg::apb_addr_t paddr_i,
   input  wire timed_flag_pkg::word_t     pwdata_i,
   output timed_flag_pkg::word_t          prdata_o,
   output logic                           pready_o,
   output logic                           pslverr_o,
   input  wire logic                      done_i,
   input  wire logic                      bank_i,
   input  wire logic                      busy_i,
   tf_cfg_if.regs                         cfg
);

   logic acc;       // access phase
   logic wr;
   logic mapped;

   assign acc = psel_i & penable_i;
   assign wr  = acc & pwrite_i;

   always_comb begin
      mapped   = 1'b1;
      prdata_o = '0;
      case (paddr_i)
         timed_flag_pkg::REG_CTRL:     prdata_o[timed_flag_pkg::CTRL_DISABLE] = cfg.disabled;
         timed_flag_pkg::REG_EXT_ADDR: prdata_o = cfg.ext_addr;
         timed_flag_pkg::REG_LENGTH:   prdata_o = 32'(cfg.length);
         timed_flag_pkg::REG_MAXIMUM:  prdata_o = cfg.maximum;
         timed_flag_pkg::REG_DELAY:    prdata_o = cfg.delay;
         timed_flag_pkg::REG_STATUS: begin
            prdata_o[timed_flag_pkg::STAT_DONE] = done_i;
            prdata_o[timed_flag_pkg::STAT_BANK] = bank_i;
         end
         default:                      mapped = 1'b0;
      endcase
   end

   assign pready_o  = 1'b1;            // no wait states
   assign pslverr_o = acc & ~mapped;

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         cfg.run      <= 1'b0;
         cfg.ext_addr <= '0;
         cfg.length   <= '0;
         cfg.maximum  <= '0;
         cfg.delay    <= '0;
         cfg.disabled <= 1'b0;
      end else begin
         cfg.run <= 1'b0;
         if (wr) begin
            case (paddr_i)
               timed_flag_pkg::REG_CTRL: begin
                  cfg.disabled <= pwdata_i[timed_flag_pkg::CTRL_DISABLE];
                  // start dropped while a burst is in flight
                  cfg.run <= pwdata_i[timed_flag_pkg::CTRL_START] & ~busy_i & ~cfg.run;
               end
               timed_flag_pkg::REG_EXT_ADDR: cfg.ext_addr <= pwdata_i;
               timed_flag_pkg::REG_LENGTH:   cfg.length   <= pwdata_i[7:0];
               timed_flag_pkg::REG_MAXIMUM:  cfg.maximum  <= pwdata_i;
               timed_flag_pkg::REG_DELAY:    cfg.delay    <= pwdata_i;
               default: ;                    // status is read only
            endcase
         end
      end
   end

endmodule

`default_nettype wire

// File: verilog/tf_buf_if.sv
`timescale 1ns/10ps
`default_nettype none

interface tf_buf_if #(
   parameter int BUF_AW = 6
) ();

   // write side, fill bank
   logic                  wr_en;
   logic [BUF_AW-1:0]     wr_addr;
   timed_flag_pkg::word_t wr_data;

   // read side, scan bank
   logic                  rd_en;
   logic [BUF_AW-1:0]     rd_addr;
   timed_flag_pkg::word_t rd_data;     // valid the cycle after rd_en
   logic [BUF_AW:0]       rd_beats;    // words stored in scan bank

   logic                  fill_bank;

   modport writer (output wr_en, wr_addr, wr_data);
   modport reader (output rd_en, rd_addr, input rd_data, rd_beats);
   modport buffer (input wr_en, wr_addr, wr_data, rd_en, rd_addr,
                   output rd_data, rd_beats, fill_bank);

endinterface

`default_nettype wire

// File: verilog/tf_cfg_if.sv
`timescale 1ns/10ps
`default_nettype none

interface tf_cfg_if #(
   parameter int BUF_AW = 6
) ();

   localparam int BANK_WORDS = 2 ** BUF_AW;

   logic                   run;         // single cycle start
   timed_flag_pkg::word_t  ext_addr;
   timed_flag_pkg::len_t   length;
   timed_flag_pkg::count_t maximum;
   timed_flag_pkg::count_t delay;
   logic                   disabled;
   logic [BUF_AW:0]        fill_beats;  // beats that fit in a bank

   // longer bursts only keep the first bank's worth
   assign fill_beats = (int'(length) > BANK_WORDS) ? (BUF_AW + 1)'(BANK_WORDS)
                                                   : (BUF_AW + 1)'(length);

   modport regs  (output run, ext_addr, length, maximum, delay, disabled);
   modport fetch (input run, ext_addr, length, fill_beats);
   modport scan  (input run, maximum, delay, disabled);

endinterface

`default_nettype wire

// File: verilog/timed_flag_pkg.sv
`default_nettype none

package timed_flag_pkg;

   typedef logic [31:0] word_t;      // one read beat, two flags
   typedef logic [15:0] flag_t;      // matched against count[15:0]
   typedef logic [31:0] count_t;
   typedef logic [7:0]  len_t;       // burst beats, from 1
   typedef logic [7:0]  apb_addr_t;

   // register map
   localparam apb_addr_t REG_CTRL     = 8'h00;
   localparam apb_addr_t REG_EXT_ADDR = 8'h04;
   localparam apb_addr_t REG_LENGTH   = 8'h08;
   localparam apb_addr_t REG_MAXIMUM  = 8'h0C;
   localparam apb_addr_t REG_DELAY    = 8'h10;
   localparam apb_addr_t REG_STATUS   = 8'h14;

   // ctrl bits
   localparam int CTRL_START   = 0;   // self clearing
   localparam int CTRL_DISABLE = 1;

   // status bits
   localparam int STAT_DONE = 0;
   localparam int STAT_BANK = 1;

endpackage

`default_nettype wire
